//--- all.f
+incdir+include
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/opcode_decoder.sv
verilog/register_file.sv
verilog/bus_cycle_unit.sv
verilog/execution_sequencer.sv
verilog/cpu8080_top.sv
tests/cpu8080_properties.sv
tests/cpu8080_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module cpu8080_tb -o cpu8080_sim

status=0
out=$(./obj_dir/cpu8080_sim) || status=$?
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

//--- tests/cpu8080_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu8080_tb
	import bus_pkg::*;
();

	localparam bus_status_t ST_FETCH = bus_status_t'(2'b11);
	localparam bus_status_t ST_READ = bus_status_t'(2'b10);
	localparam bus_status_t ST_WRITE = bus_status_t'(2'b01);
	// slowest cycle is ten clocks, plus margin
	localparam int CLOCKS_PER_CYCLE = 12;

	logic        clock = 1'b0;
	logic        reset_in = 1'b1;
	logic        ready = 1'b0;
	bus_data_t   rdata = '0;
	bus_addr_t   addr;
	bus_data_t   wdata;
	logic        rd_n;
	logic        wr_n;
	bus_status_t status;

	// memory image, live memory and reference copy
	bus_data_t   image [65536];
	bus_data_t   mem [65536];
	bus_data_t   ref_mem [65536];
	logic        slow_mem = 1'b0;
	int unsigned wait_left;
	// wait counts drawn up front from the seeded stream
	int unsigned wait_draw [256];
	logic [7:0]  wait_pos;

	// expected results from the reference
	bus_addr_t   exp_fetch [$];
	bus_addr_t   exp_waddr [$];
	bus_data_t   exp_wdata [$];
	int          exp_wtest [$];
	bus_addr_t   seg_start [6];
	int          last_write [6];
	int          test_err [6];
	string       test_name [6];
	bus_addr_t   prog_end;
	int          bus_cycles;

	int          pass_id = 0;
	logic        pass_done = 1'b0;
	logic        in_strobe;
	int          fetch_idx;
	int          write_idx;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles;
	int          limit;
	logic        timed_out = 1'b0;

	always #4 clock = ~clock;

	cpu8080_top cpu8080_top_i (
		.clock    (clock),
		.reset_in (reset_in),
		.ready    (ready),
		.rdata    (rdata),
		.addr     (addr),
		.wdata    (wdata),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.status   (status)
	);

	bind bus_cycle_unit cpu8080_properties cpu8080_properties_i (
		.clock    (clock),
		.reset_in (reset_in),
		.addr     (addr),
		.wdata    (wdata),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.ready    (ready)
	);

	// memory model, one edge of access time then 0 to 3 random waits
	always @(posedge clock) begin
		if (reset_in) begin
			mem <= image;
			ready <= 1'b0;
			rdata <= '0;
			wait_left <= 0;
			wait_pos <= '0;
		end else begin
			rdata <= mem[addr];
			if (!wr_n) mem[addr] <= wdata;
			if (rd_n && wr_n) begin
				ready <= 1'b0;
				wait_left <= slow_mem ? wait_draw[wait_pos] : 32'd0;
				wait_pos <= wait_pos + 8'd1;
			end else if (wait_left == 0) begin
				ready <= 1'b1;
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

	function automatic void count_error(input int test);
		errors++;
		test_err[test]++;
	endfunction

	task automatic check_write(input int test, input bus_addr_t got_addr,
			input bus_data_t got_data, input bus_status_t got_status,
			input bus_addr_t exp_addr, input bus_data_t exp_data);
		checks++;
		if (got_addr !== exp_addr) begin
			count_error(test);
			$display("FAIL t=%0t addr: got %h expected %h", $time, got_addr, exp_addr);
		end
		if (got_data !== exp_data) begin
			count_error(test);
			$display("FAIL t=%0t wdata: got %h expected %h", $time, got_data, exp_data);
		end
		if (got_status !== ST_WRITE) begin
			count_error(test);
			$display("FAIL t=%0t status: got %b expected %b", $time, got_status, ST_WRITE);
		end
	endtask

	task automatic check_fetch(input int test, input bus_addr_t got_addr,
			input bus_status_t got_status, input bus_addr_t exp_addr);
		checks++;
		if (got_addr !== exp_addr) begin
			count_error(test);
			$display("FAIL t=%0t fetch addr: got %h expected %h", $time, got_addr, exp_addr);
		end
		if (got_status !== ST_FETCH) begin
			count_error(test);
			$display("FAIL t=%0t status: got %b expected %b", $time, got_status, ST_FETCH);
		end
	endtask

	task automatic report_test(input int test);
		tests_run++;
		if (test_err[test] == 0) begin
			$display("test %0d %s: ok", test, test_name[test]);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test, test_name[test], test_err[test]);
		end
	endtask

	// lay one instruction into the image
	task automatic put_instr(input int len, input bus_data_t b0, input bus_data_t b1,
			input bus_data_t b2);
		image[prog_end] = b0;
		if (len > 1) image[prog_end + 16'd1] = b1;
		if (len > 2) image[prog_end + 16'd2] = b2;
		prog_end = prog_end + 16'(len);
	endtask

	task automatic build_program();
		bus_addr_t a;
		for (int i = 0; i < 65536; i++) begin
			a = 16'(i);
			image[i] = '0;
			// data page, mixes every address bit
			if (a[15:8] == 8'h20) image[i] = {a[3:0], a[7:4]} ^ a[15:8] ^ 8'h96;
		end
		prog_end = `CPU_RESET_PC;
		put_instr(2, 8'h06, 8'h5A, 8'h00); // mvi b
		put_instr(1, 8'h48, 8'h00, 8'h00); // mov c,b
		put_instr(3, 8'h21, 8'h30, 8'h20); // lxi h,2030
		put_instr(1, 8'h71, 8'h00, 8'h00); // mov m,c
		seg_start[2] = prog_end;
		put_instr(2, 8'h36, 8'h77, 8'h00); // mvi m
		put_instr(1, 8'h5E, 8'h00, 8'h00); // mov e,m
		put_instr(3, 8'h21, 8'h40, 8'h20); // lxi h,2040
		put_instr(1, 8'h73, 8'h00, 8'h00); // mov m,e
		seg_start[3] = prog_end;
		put_instr(3, 8'h32, 8'h08, 8'h20); // sta before any load
		put_instr(3, 8'h3A, 8'h00, 8'h20); // lda 2000
		put_instr(3, 8'h32, 8'h10, 8'h20); // sta 2010
		seg_start[4] = prog_end;
		put_instr(3, 8'h2A, 8'h04, 8'h20); // lhld 2004
		put_instr(3, 8'h22, 8'h20, 8'h20); // shld 2020
		put_instr(1, 8'hC3, 8'h00, 8'h00); // jmp, skipped as one byte
	endtask

	function automatic void expect_write(input bus_addr_t a, input bus_data_t d, input int tag);
		exp_waddr.push_back(a);
		exp_wdata.push_back(d);
		exp_wtest.push_back(tag);
		ref_mem[a] = d;
		last_write[tag] = exp_waddr.size() - 1;
	endfunction

	// 8080 data transfer rules on a private register and memory model
	function automatic void interpret_program();
		bus_data_t regs [8];
		bus_addr_t pc;
		bus_addr_t nn;
		bus_addr_t hl;
		bus_data_t opc;
		bus_data_t b1;
		bus_data_t b2;
		int tag;
		regs = '{default: 8'h00};
		regs[7] = `CPU_A_RESET;
		ref_mem = image;
		pc = `CPU_RESET_PC;
		bus_cycles = 0;
		while (pc != prog_end) begin
			opc = ref_mem[pc];
			b1 = ref_mem[pc + 16'd1];
			b2 = ref_mem[pc + 16'd2];
			nn = {b2, b1};
			hl = {regs[4], regs[5]};
			tag = 1;
			for (int t = 2; t <= 4; t++) if (pc >= seg_start[t]) tag = t;
			exp_fetch.push_back(pc);
			if (opc[7:6] == 2'b01 && opc != 8'h76) begin
				if (opc[2:0] == 3'd6) begin
					regs[opc[5:3]] = ref_mem[hl];
					bus_cycles += 2;
				end else if (opc[5:3] == 3'd6) begin
					expect_write(hl, regs[opc[2:0]], tag);
					bus_cycles += 2;
				end else begin
					regs[opc[5:3]] = regs[opc[2:0]];
					bus_cycles += 1;
				end
				pc = pc + 16'd1;
			end else if (opc[7:6] == 2'b00 && opc[2:0] == 3'd6) begin
				if (opc[5:3] == 3'd6) begin
					expect_write(hl, b1, tag);
					bus_cycles += 3;
				end else begin
					regs[opc[5:3]] = b1;
					bus_cycles += 2;
				end
				pc = pc + 16'd2;
			end else if (opc[7:6] == 2'b00 && opc[3:0] == 4'h1 && opc[5:4] != 2'b11) begin
				// high byte register first in the pair code
				regs[{opc[5:4], 1'b0}] = b2;
				regs[{opc[5:4], 1'b1}] = b1;
				bus_cycles += 3;
				pc = pc + 16'd3;
			end else begin
				case (opc)
					8'h3A: regs[7] = ref_mem[nn];
					8'h32: expect_write(nn, regs[7], tag);
					8'h2A: begin
						regs[5] = ref_mem[nn];
						regs[4] = ref_mem[nn + 16'd1];
					end
					8'h22: begin
						expect_write(nn, regs[5], tag);
						expect_write(nn + 16'd1, regs[4], tag);
					end
					default: ;
				endcase
				if (opc == 8'h3A || opc == 8'h32) bus_cycles += 4;
				else if (opc == 8'h2A || opc == 8'h22) bus_cycles += 5;
				else bus_cycles += 1;
				// anything outside the kept set is a one byte no-op
				pc = (opc == 8'h3A || opc == 8'h32 || opc == 8'h2A || opc == 8'h22) ?
					pc + 16'd3 : pc + 16'd1;
			end
		end
		// first fetch past the program closes the last instruction
		exp_fetch.push_back(pc);
		bus_cycles += 1;
	endfunction

	// compare process, one check per strobe as it starts
	always @(posedge clock) begin
		if (reset_in) begin
			fetch_idx = 0;
			write_idx = 0;
			in_strobe = 1'b0;
			pass_done <= 1'b0;
		end else begin
			if (rd_n && wr_n) begin
				in_strobe = 1'b0;
			end else if (!in_strobe) begin
				in_strobe = 1'b1;
				if (!wr_n && write_idx >= exp_waddr.size()) begin
					count_error(pass_id == 1 ? 5 : 0);
					$display("t=%0t unexpected write of %h to %h", $time, wdata, addr);
				end else if (!wr_n) begin
					check_write(pass_id == 1 ? 5 : exp_wtest[write_idx], addr, wdata, status,
						exp_waddr[write_idx], exp_wdata[write_idx]);
					if (pass_id == 0 && write_idx == last_write[exp_wtest[write_idx]])
						report_test(exp_wtest[write_idx]);
					write_idx++;
				end else if (status != ST_READ) begin
					if (fetch_idx < exp_fetch.size())
						check_fetch(pass_id == 1 ? 5 : 0, addr, status, exp_fetch[fetch_idx]);
					fetch_idx++;
				end
			end
			pass_done <= (fetch_idx >= exp_fetch.size()) && (write_idx >= exp_waddr.size());
		end
	end

	task automatic apply_reset(input int pass);
		reset_in <= 1'b1;
		pass_id <= pass;
		slow_mem <= (pass == 1);
		repeat (3) @(posedge clock);
		reset_in <= 1'b0;
	endtask

	initial begin
		wait_draw[0] = $urandom(32'hca08_5851) % 4;
		for (int i = 1; i < 256; i++) wait_draw[i] = $urandom_range(3, 0);
		test_name[0] = "fetch addresses";
		test_name[1] = "mvi and mov through hl";
		test_name[2] = "mvi m and memory to memory move";
		test_name[3] = "lda and sta";
		test_name[4] = "lhld and shld";
		test_name[5] = "random wait states";
		last_write = '{default: -1};
		test_err = '{default: 0};
		build_program();
		interpret_program();
		limit = bus_cycles * CLOCKS_PER_CYCLE + 50;
		// pass 0 with the fastest memory, pass 1 with random waits
		for (int p = 0; p < 2 && !timed_out; p++) begin
			apply_reset(p);
			cycles = 0;
			while (!pass_done && cycles < limit) begin
				@(posedge clock);
				cycles++;
			end
			if (!pass_done) begin
				timed_out = 1'b1;
				$display("timeout: pass %0d did not finish its program in %0d cycles", p, limit);
			end else begin
				report_test(p == 0 ? 0 : 5);
			end
		end
		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tests/cpu8080_properties.sv
`timescale 1ns/1ps

module cpu8080_properties
	import bus_pkg::*;
(
	input logic      clock,
	input logic      reset_in,
	input bus_addr_t addr,
	input bus_data_t wdata,
	input logic      rd_n,
	input logic      wr_n,
	input logic      ready
);

	logic strobe_low;

	assign strobe_low = !rd_n || !wr_n;

	// one strobe at a time
	strobes_exclusive: assert property (
		@(posedge clock) disable iff (reset_in) rd_n || wr_n
	) else $error("rd_n and wr_n are low in the same cycle");

	// address and write data frozen under the strobe
	bus_stable: assert property (
		@(posedge clock) disable iff (reset_in)
		(strobe_low && $past(strobe_low)) |-> ($stable(addr) && $stable(wdata))
	) else $error("addr or wdata changed while a strobe was low");

	// strobe rises two edges after ready was sampled high
	strobe_waits_ready: assert property (
		@(posedge clock) disable iff (reset_in)
		($rose(rd_n) || $rose(wr_n)) |-> $past(ready, 2)
	) else $error("strobe released without ready seen high");

	// both strobes idle right after reset
	idle_after_reset: assert property (
		@(posedge clock) $fell(reset_in) |-> (rd_n && wr_n)
	) else $error("a strobe is low in the first cycle after reset");

endmodule

//--- verilog/cpu8080_top.sv
`timescale 1ns/1ps

module cpu8080_top
	import isa_pkg::*;
	import bus_pkg::*;
(
	input  logic        clock,
	input  logic        reset_in,
	input  logic        ready,
	input  bus_data_t   rdata,
	output bus_addr_t   addr,
	output bus_data_t   wdata,
	output logic        rd_n,
	output logic        wr_n,
	output bus_status_t status
);

	bus_data_t   ir;
	decoded_op_t op;
	reg_code_t   rcode;
	reg_code_t   wcode;
	logic        we;
	bus_data_t   reg_wdata;
	bus_data_t   rvalue;
	bus_addr_t   hl;
	bus_req_t    req;
	bus_rsp_t    rsp;

	// decode straight off the instruction register
	opcode_decoder opcode_decoder_i (
		.ir (ir),
		.op (op)
	);

	register_file register_file_i (
		.clock    (clock),
		.reset_in (reset_in),
		.we       (we),
		.wcode    (wcode),
		.wdata    (reg_wdata),
		.rcode    (rcode),
		.rvalue   (rvalue),
		.hl       (hl)
	);

	// one memory cycle at a time
	bus_cycle_unit bus_cycle_unit_i (
		.clock    (clock),
		.reset_in (reset_in),
		.req      (req),
		.rdata    (rdata),
		.ready    (ready),
		.rsp      (rsp),
		.addr     (addr),
		.wdata    (wdata),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.status   (status)
	);

	execution_sequencer execution_sequencer_i (
		.clock    (clock),
		.reset_in (reset_in),
		.op       (op),
		.rvalue   (rvalue),
		.hl       (hl),
		.rsp      (rsp),
		.ir       (ir),
		.rcode    (rcode),
		.we       (we),
		.wcode    (wcode),
		.wdata    (reg_wdata),
		.req      (req)
	);

endmodule

//--- verilog/execution_sequencer.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execution_sequencer
	import isa_pkg::*;
	import bus_pkg::*;
(
	input  logic        clock,
	input  logic        reset_in,
	input  decoded_op_t op,
	input  bus_data_t   rvalue,
	input  bus_addr_t   hl,
	input  bus_rsp_t    rsp,
	output bus_data_t   ir,
	output reg_code_t   rcode,
	output logic        we,
	output reg_code_t   wcode,
	output bus_data_t   wdata,
	output bus_req_t    req
);

	// issue builds the next request, wait sits until done
	typedef enum logic {
		PH_ISSUE,
		PH_WAIT
	} seq_phase_t;

	seq_phase_t  phase;
	// machine cycle of the current instruction, 0 is the opcode fetch
	logic [2:0]  mcycle;
	bus_addr_t   pc;
	// cycle in flight reads at pc
	logic        imm_q;
	bus_data_t   w_q;
	bus_data_t   z_q;
	bus_addr_t   wz;
	bus_addr_t   wz_inc;
	cycle_kind_t nxt_kind;
	bus_addr_t   nxt_addr;
	bus_data_t   nxt_wdata;
	logic        nxt_imm;

	assign wz = {w_q, z_q};
	assign wz_inc = wz + 1'b1;

	// next bus cycle, fetch once the instruction runs out of cycles
	always_comb begin
		nxt_kind = FETCH;
		nxt_addr = pc;
		nxt_wdata = '0;
		nxt_imm = 1'b1;
		rcode = op.src;
		if (mcycle != 3'd0) begin
			case (op.cls)
				MOV_RM: if (mcycle == 3'd1) begin
					nxt_kind = READ;
					nxt_addr = hl;
					nxt_imm = 1'b0;
				end
				MOV_MR: if (mcycle == 3'd1) begin
					nxt_kind = WRITE;
					nxt_addr = hl;
					nxt_wdata = rvalue;
					nxt_imm = 1'b0;
				end
				MVI_R: if (mcycle == 3'd1) nxt_kind = READ;
				LXI: if (mcycle <= 3'd2) nxt_kind = READ;
				MVI_M: begin
					if (mcycle == 3'd1) begin
						nxt_kind = READ;
					end else if (mcycle == 3'd2) begin
						// immediate byte parked in z
						nxt_kind = WRITE;
						nxt_addr = hl;
						nxt_wdata = z_q;
						nxt_imm = 1'b0;
					end
				end
				LDA, STA, LHLD, SHLD: begin
					if (mcycle <= 3'd2) begin
						// address bytes into z then w
						nxt_kind = READ;
					end else if (mcycle == 3'd3) begin
						nxt_kind = (op.cls == LDA || op.cls == LHLD) ? READ : WRITE;
						nxt_addr = wz;
						rcode = op.dst;
						nxt_wdata = rvalue;
						nxt_imm = 1'b0;
					end else if (mcycle == 3'd4 && op.cls != LDA && op.cls != STA) begin
						// second byte of the pair at w:z+1
						nxt_kind = (op.cls == LHLD) ? READ : WRITE;
						nxt_addr = wz_inc;
						rcode = op.src;
						nxt_wdata = rvalue;
						nxt_imm = 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

	// register file write port
	always_comb begin
		we = 1'b0;
		wcode = op.dst;
		wdata = rsp.rdata;
		if (phase == PH_ISSUE) begin
			// mov r,r needs no bus cycle
			if (mcycle == 3'd1 && op.cls == MOV_RR) begin
				we = 1'b1;
				wdata = rvalue;
			end
		end else if (rsp.done) begin
			case (op.cls)
				MOV_RM, MVI_R: we = (mcycle == 3'd1);
				LXI: begin
					we = (mcycle == 3'd1) || (mcycle == 3'd2);
					if (mcycle == 3'd2) wcode = op.src;
				end
				LDA: we = (mcycle == 3'd3);
				LHLD: begin
					we = (mcycle == 3'd3) || (mcycle == 3'd4);
					if (mcycle == 3'd4) wcode = op.src;
				end
				default: we = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset_in) begin
			// first fetch goes out right after reset
			phase <= PH_WAIT;
			mcycle <= 3'd0;
			pc <= `CPU_RESET_PC;
			ir <= '0;
			imm_q <= 1'b1;
			req <= '{valid: 1'b1, kind: FETCH, addr: `CPU_RESET_PC, wdata: '0};
		end else if (phase == PH_ISSUE) begin
			req <= '{valid: 1'b1, kind: nxt_kind, addr: nxt_addr, wdata: nxt_wdata};
			imm_q <= nxt_imm;
			phase <= PH_WAIT;
			if (nxt_kind == FETCH) mcycle <= 3'd0;
		end else if (rsp.done) begin
			req.valid <= 1'b0;
			phase <= PH_ISSUE;
			mcycle <= mcycle + 3'd1;
			if (imm_q) pc <= pc + 1'b1;
			if (mcycle == 3'd0) ir <= rsp.rdata;
		end
	end

	// w and z temporaries
	always_ff @(posedge clock) begin
		if (phase == PH_WAIT && rsp.done) begin
			if (mcycle == 3'd1) z_q <= rsp.rdata;
			if (mcycle == 3'd2) w_q <= rsp.rdata;
		end
	end

endmodule

//--- verilog/bus_cycle_unit.sv
`timescale 1ns/1ps

module bus_cycle_unit
	import bus_pkg::*;
(
	input  logic        clock,
	input  logic        reset_in,
	input  bus_req_t    req,
	input  bus_data_t   rdata,
	input  logic        ready,
	output bus_rsp_t    rsp,
	output bus_addr_t   addr,
	output bus_data_t   wdata,
	output logic        rd_n,
	output logic        wr_n,
	output bus_status_t status
);

	// setup takes the place of the old ale slot
	typedef enum logic [1:0] {
		BC_IDLE,
		BC_SETUP,
		BC_STROBE,
		BC_FINISH
	} bc_state_t;

	bc_state_t   state;
	logic        done_q;
	bus_data_t   rdata_q;
	bus_status_t kind_status;

	// status pins from cycle kind
	always_comb begin
		case (req.kind)
			FETCH: kind_status = '{s1: 1'b1, s0: 1'b1};
			READ: kind_status = '{s1: 1'b1, s0: 1'b0};
			WRITE: kind_status = '{s1: 1'b0, s0: 1'b1};
			default: kind_status = '{s1: 1'b0, s0: 1'b0};
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_in) begin
			state <= BC_IDLE;
			rd_n <= 1'b1;
			wr_n <= 1'b1;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				// stale valid still up while done shows, skip it
				BC_IDLE: if (req.valid && !done_q) state <= BC_SETUP;
				BC_SETUP: begin
					state <= BC_STROBE;
					rd_n <= (req.kind == WRITE);
					wr_n <= (req.kind != WRITE);
				end
				// wait states while ready is low
				BC_STROBE: if (ready) state <= BC_FINISH;
				BC_FINISH: begin
					state <= BC_IDLE;
					rd_n <= 1'b1;
					wr_n <= 1'b1;
					done_q <= 1'b1;
				end
				default: state <= BC_IDLE;
			endcase
		end
	end

	// address, data and status hold for the whole strobe
	always_ff @(posedge clock) begin
		if (state == BC_SETUP) begin
			addr <= req.addr;
			wdata <= req.wdata;
			status <= kind_status;
		end
		if (state == BC_STROBE && ready) rdata_q <= rdata;
	end

	assign rsp = '{done: done_q, rdata: rdata_q};

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file
	import isa_pkg::*;
	import bus_pkg::*;
(
	input  logic      clock,
	input  logic      reset_in,
	input  logic      we,
	input  reg_code_t wcode,
	input  bus_data_t wdata,
	input  reg_code_t rcode,
	output bus_data_t rvalue,
	output bus_addr_t hl
);

	// the seven programmer visible registers
	bus_data_t b_q;
	bus_data_t c_q;
	bus_data_t d_q;
	bus_data_t e_q;
	bus_data_t h_q;
	bus_data_t l_q;
	bus_data_t a_q;

	// single write port
	always_ff @(posedge clock) begin
		if (reset_in) begin
			b_q <= '0;
			c_q <= '0;
			d_q <= '0;
			e_q <= '0;
			h_q <= '0;
			l_q <= '0;
			a_q <= `CPU_A_RESET;
		end else if (we) begin
			case (wcode)
				REG_B: b_q <= wdata;
				REG_C: c_q <= wdata;
				REG_D: d_q <= wdata;
				REG_E: e_q <= wdata;
				REG_H: h_q <= wdata;
				REG_L: l_q <= wdata;
				REG_A: a_q <= wdata;
				// m lives in memory, nothing to store
				default: ;
			endcase
		end
	end

	// selected read port
	always_comb begin
		case (rcode)
			REG_B: rvalue = b_q;
			REG_C: rvalue = c_q;
			REG_D: rvalue = d_q;
			REG_E: rvalue = e_q;
			REG_H: rvalue = h_q;
			REG_L: rvalue = l_q;
			REG_A: rvalue = a_q;
			REG_M: rvalue = '0;
			default: rvalue = '0;
		endcase
	end

	// memory pointer for m operands
	assign hl = {h_q, l_q};

endmodule

//--- verilog/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder
	import isa_pkg::*;
	import bus_pkg::*;
(
	input  bus_data_t   ir,
	output decoded_op_t op
);

	// low fields of the 00 group
	localparam logic [2:0] LOW_MVI = 3'b110;
	localparam logic [3:0] LOW_LXI = 4'b0001;
	// lxi sp is not kept
	localparam logic [1:0] PAIR_SP = 2'b11;

	// direct address loads and stores
	localparam logic [5:0] OP_LDA  = 6'h3A;
	localparam logic [5:0] OP_STA  = 6'h32;
	localparam logic [5:0] OP_LHLD = 6'h2A;
	localparam logic [5:0] OP_SHLD = 6'h22;

	always_comb begin
		// plain ddd/sss fields by default
		op.cls = NOP;
		op.dst = ir[5:3];
		op.src = ir[2:0];
		case (ir[7:6])
			2'b01: begin
				// 76h would be hlt, skipped here
				if (ir[5:3] == REG_M && ir[2:0] == REG_M) begin
					op.cls = NOP;
				end else if (ir[2:0] == REG_M) begin
					op.cls = MOV_RM;
				end else if (ir[5:3] == REG_M) begin
					op.cls = MOV_MR;
				end else begin
					op.cls = MOV_RR;
				end
			end
			2'b00: begin
				if (ir[2:0] == LOW_MVI) begin
					op.cls = (ir[5:3] == REG_M) ? MVI_M : MVI_R;
				end else if (ir[3:0] == LOW_LXI && ir[5:4] != PAIR_SP) begin
					// low byte comes first on the bus
					op.cls = LXI;
					op.dst = {ir[5:4], 1'b1};
					op.src = {ir[5:4], 1'b0};
				end else begin
					case (ir[5:0])
						OP_LDA: begin
							op.cls = LDA;
							op.dst = REG_A;
							op.src = REG_A;
						end
						OP_STA: begin
							op.cls = STA;
							op.dst = REG_A;
							op.src = REG_A;
						end
						OP_LHLD: begin
							op.cls = LHLD;
							op.dst = REG_L;
							op.src = REG_H;
						end
						OP_SHLD: begin
							op.cls = SHLD;
							op.dst = REG_L;
							op.src = REG_H;
						end
						default: op.cls = NOP;
					endcase
				end
			end
			default: op.cls = NOP;
		endcase
	end

endmodule

//--- verilog/bus_pkg.sv
`include "cpu_params.svh"

package bus_pkg;

	typedef logic [`CPU_ADDR_W-1:0] bus_addr_t;
	typedef logic [`CPU_DATA_W-1:0] bus_data_t;

	// every cycle is a memory cycle
	typedef enum logic [1:0] {
		FETCH,
		READ,
		WRITE
	} cycle_kind_t;

	// held steady by the requester until done comes back
	typedef struct packed {
		logic        valid;
		cycle_kind_t kind;
		bus_addr_t   addr;
		bus_data_t   wdata;
	} bus_req_t;

	// done is a single cycle pulse
	typedef struct packed {
		logic      done;
		bus_data_t rdata;
	} bus_rsp_t;

	// 8080 status pins
	// fetch 11, read 10, write 01
	typedef struct packed {
		logic s1;
		logic s0;
	} bus_status_t;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

	// 3-bit register field as it sits in the opcode
	typedef logic [2:0] reg_code_t;

	localparam reg_code_t REG_B = 3'd0;
	localparam reg_code_t REG_C = 3'd1;
	localparam reg_code_t REG_D = 3'd2;
	localparam reg_code_t REG_E = 3'd3;
	localparam reg_code_t REG_H = 3'd4;
	localparam reg_code_t REG_L = 3'd5;
	// memory operand addressed by hl
	localparam reg_code_t REG_M = 3'd6;
	localparam reg_code_t REG_A = 3'd7;

	// data transfer group only
	// everything else runs as a one byte no-op
	typedef enum logic [3:0] {
		MOV_RR,
		MOV_RM,
		MOV_MR,
		MVI_R,
		MVI_M,
		LXI,
		LDA,
		STA,
		LHLD,
		SHLD,
		NOP
	} instr_class_t;

	// register pair ops (lxi, lhld, shld)
	// dst names the low byte register and src the high one
	typedef struct packed {
		instr_class_t cls;
		reg_code_t    dst;
		reg_code_t    src;
	} decoded_op_t;

endpackage

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first opcode fetch after reset
`define CPU_RESET_PC 16'h0100

// accumulator after reset
// all other registers come up as zero
`define CPU_A_RESET 8'hAD

// memory bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

`endif
